//--- source/sysbus_pkg.sv
`default_nettype none

package sysbus_pkg;

    // ============================================================
    // Bus and line geometry
    // ============================================================
    localparam int bus_data_width    = 64;
    localparam int beats_per_line    = 8;
    localparam int line_width        = bus_data_width * beats_per_line;
    localparam int line_offset_width = 6;    // Byte offset within a line.
    localparam int bus_tag_width     = 13;

    // Tag codes.
    localparam logic       sysbus_write  = 1'b1;
    localparam logic       sysbus_read   = 1'b0;
    localparam logic [3:0] sysbus_memory = 4'b0001;

    // Memory size.
    localparam int line_count       = 16;
    localparam int line_index_width = 4;

    // ============================================================
    // State codes
    // ============================================================
    // Shared by both bus masters.
    localparam logic [2:0] mst_idle     = 3'd0;
    localparam logic [2:0] mst_request  = 3'd1;
    localparam logic [2:0] mst_address  = 3'd2;
    localparam logic [2:0] mst_transfer = 3'd3;
    localparam logic [2:0] mst_ready    = 3'd4;

    localparam logic [1:0] mem_idle        = 2'd0;
    localparam logic [1:0] mem_write       = 2'd1;
    localparam logic [1:0] mem_read_wait   = 2'd2;
    localparam logic [1:0] mem_read_stream = 2'd3;

    // Bus tag word, seen as fields or as one raw word.
    typedef union packed {
        struct packed {
            logic       dir;       // Bit 12.
            logic [3:0] device;    // Bits 11..8.
            logic [7:0] spare;     // Always zero.
        } f;
        logic [bus_tag_width-1:0] raw;
    } bus_tag_u;

endpackage

`default_nettype wire

//--- source/bus_arbiter.sv
`default_nettype none

module bus_arbiter
(
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                wb_reqcyc_arb,
    input  logic                                fill_reqcyc_arb,
    input  logic                                wb_busy,
    input  logic                                fill_busy,
    input  logic                                wb_bus_reqcyc,
    input  logic [sysbus_pkg::bus_data_width-1:0] wb_bus_req,
    input  logic [sysbus_pkg::bus_tag_width-1:0]  wb_bus_reqtag,
    input  logic                                fill_bus_reqcyc,
    input  logic [sysbus_pkg::bus_data_width-1:0] fill_bus_req,
    input  logic [sysbus_pkg::bus_tag_width-1:0]  fill_bus_reqtag,
    output logic                                wb_grant,
    output logic                                fill_grant,
    output logic                                main_bus_reqcyc,
    output logic [sysbus_pkg::bus_data_width-1:0] main_bus_req,
    output logic [sysbus_pkg::bus_tag_width-1:0]  main_bus_reqtag
);
    import sysbus_pkg::*;

    logic busy_seen;
    logic owner_busy;

    assign owner_busy = wb_grant ? wb_busy : fill_busy;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wb_grant   <= 1'b0;
            fill_grant <= 1'b0;
            busy_seen  <= 1'b0;
        end
        else if (!wb_grant && !fill_grant)
        begin
            wb_grant   <= wb_reqcyc_arb;                       // Write-back wins.
            fill_grant <= fill_reqcyc_arb && !wb_reqcyc_arb;
            busy_seen  <= 1'b0;
        end
        else if (owner_busy)
        begin
            busy_seen <= 1'b1;
        end
        else if (busy_seen)
        begin
            wb_grant   <= 1'b0;                                // Owner is done.
            fill_grant <= 1'b0;
            busy_seen  <= 1'b0;
        end
    end

    always_comb
    begin
        main_bus_reqcyc = 1'b0;
        main_bus_req    = '0;
        main_bus_reqtag = '0;
        if (wb_grant)
        begin
            main_bus_reqcyc = wb_bus_reqcyc;
            main_bus_req    = wb_bus_req;
            main_bus_reqtag = wb_bus_reqtag;
        end
        else if (fill_grant)
        begin
            main_bus_reqcyc = fill_bus_reqcyc;
            main_bus_req    = fill_bus_req;
            main_bus_reqtag = fill_bus_reqtag;
        end
    end

    // Only the granted master may be busy on the bus.
    a_single_owner: assert property (@(posedge clk) disable iff (reset)
        !(wb_busy && !wb_grant) && !(fill_busy && !fill_grant));

endmodule

`default_nettype wire

//--- source/line_writeback.sv
`default_nettype none

module line_writeback
(
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                enable,
    input  logic [sysbus_pkg::bus_data_width-1:0] addr,
    input  logic [sysbus_pkg::line_width-1:0]     data,
    input  logic                                abtr_grant,
    input  logic                                main_bus_reqack,
    output logic                                abtr_reqcyc,
    output logic                                bus_busy,
    output logic                                main_bus_reqcyc,
    output logic [sysbus_pkg::bus_data_width-1:0] main_bus_req,
    output logic [sysbus_pkg::bus_tag_width-1:0]  main_bus_reqtag,
    output logic                                ready
);
    import sysbus_pkg::*;

    logic [2:0] state;
    logic [2:0] next_state;
    logic [$clog2(beats_per_line)-1:0] beat;
    logic [bus_data_width-line_offset_width-1:0] line_addr_q;
    logic [line_width-1:0] data_q;
    bus_tag_u req_tag;

    always_comb
    begin
        next_state = state;
        case (state)
            mst_idle,
            mst_ready:    if (enable) next_state = mst_request;
            mst_request:  if (abtr_grant) next_state = mst_address;
            mst_address:  next_state = mst_transfer;
            mst_transfer: if (beat == 3'(beats_per_line - 1)) next_state = mst_ready;
            default:      next_state = mst_idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= mst_idle;
            beat  <= '0;
        end
        else
        begin
            state <= next_state;
            if (state == mst_address)
                beat <= '0;
            else if (state == mst_transfer)
                beat <= beat + 1'b1;
        end
    end

    // Line captured when a new write is accepted.
    always_ff @(posedge clk)
    begin
        if ((state == mst_idle || state == mst_ready) && enable)
        begin
            line_addr_q <= addr[bus_data_width-1:line_offset_width];
            data_q      <= data;
        end
    end

    // ============================================================
    // Request channel
    // ============================================================
    always_comb
    begin
        req_tag = '0;
        if (main_bus_reqcyc)
        begin
            req_tag.f.dir    = sysbus_write;
            req_tag.f.device = sysbus_memory;
        end
    end

    assign abtr_reqcyc     = (state == mst_request);
    assign bus_busy        = (state == mst_address) || (state == mst_transfer);
    assign main_bus_reqcyc = bus_busy;
    assign main_bus_reqtag = req_tag.raw;
    assign ready           = (state == mst_ready);

    always_comb
    begin
        main_bus_req = '0;
        if (state == mst_address)
            main_bus_req = {line_addr_q, {line_offset_width{1'b0}}};   // Line aligned.
        else if (state == mst_transfer)
            main_bus_req = data_q[beat*bus_data_width +: bus_data_width];
    end

    // Beats go out only under grant, and the memory takes each one.
    a_beat_owned: assert property (@(posedge clk) disable iff (reset)
        main_bus_reqcyc |-> abtr_grant && main_bus_reqack);

endmodule

`default_nettype wire

//--- source/line_fill.sv
`default_nettype none

module line_fill
(
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                enable,
    input  logic [sysbus_pkg::bus_data_width-1:0] addr,
    input  logic                                abtr_grant,
    input  logic                                main_bus_respcyc,
    input  logic [sysbus_pkg::bus_data_width-1:0] main_bus_resp,
    input  logic [sysbus_pkg::bus_tag_width-1:0]  main_bus_resptag,
    output logic                                abtr_reqcyc,
    output logic                                bus_busy,
    output logic                                main_bus_reqcyc,
    output logic [sysbus_pkg::bus_data_width-1:0] main_bus_req,
    output logic [sysbus_pkg::bus_tag_width-1:0]  main_bus_reqtag,
    output logic                                main_bus_respack,
    output logic [sysbus_pkg::line_width-1:0]     line,
    output logic                                ready
);
    import sysbus_pkg::*;

    logic [2:0] state;
    logic [2:0] next_state;
    logic [$clog2(beats_per_line)-1:0] beat;
    logic [bus_data_width-line_offset_width-1:0] line_addr_q;
    logic accept;
    bus_tag_u req_tag;
    bus_tag_u resp_tag;

    assign resp_tag = main_bus_resptag;
    assign accept   = (state == mst_transfer) && main_bus_respcyc
                      && (resp_tag.f.dir == sysbus_read);

    always_comb
    begin
        next_state = state;
        case (state)
            mst_idle,
            mst_ready:    if (enable) next_state = mst_request;
            mst_request:  if (abtr_grant) next_state = mst_address;
            mst_address:  next_state = mst_transfer;
            mst_transfer: if (accept && beat == 3'(beats_per_line - 1)) next_state = mst_ready;
            default:      next_state = mst_idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= mst_idle;
            beat  <= '0;
        end
        else
        begin
            state <= next_state;
            if (state == mst_address)
                beat <= '0;
            else if (accept)
                beat <= beat + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if ((state == mst_idle || state == mst_ready) && enable)
            line_addr_q <= addr[bus_data_width-1:line_offset_width];
        if (accept)
            line[beat*bus_data_width +: bus_data_width] <= main_bus_resp;  // Into its slot.
    end

    // ============================================================
    // Request channel
    // ============================================================
    always_comb
    begin
        req_tag = '0;
        if (main_bus_reqcyc)
        begin
            req_tag.f.dir    = sysbus_read;
            req_tag.f.device = sysbus_memory;
        end
    end

    assign abtr_reqcyc      = (state == mst_request);
    assign bus_busy         = (state == mst_address) || (state == mst_transfer);
    assign main_bus_reqcyc  = (state == mst_address);
    assign main_bus_reqtag  = req_tag.raw;
    assign main_bus_respack = accept;
    assign ready            = (state == mst_ready);

    always_comb
    begin
        main_bus_req = '0;
        if (main_bus_reqcyc)
            main_bus_req = {line_addr_q, {line_offset_width{1'b0}}};
    end

endmodule

`default_nettype wire

//--- source/line_memory.sv
`default_nettype none

module line_memory
(
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                main_bus_reqcyc,
    input  logic [sysbus_pkg::bus_data_width-1:0] main_bus_req,
    input  logic [sysbus_pkg::bus_tag_width-1:0]  main_bus_reqtag,
    output logic                                main_bus_reqack,
    output logic                                main_bus_respcyc,
    output logic [sysbus_pkg::bus_data_width-1:0] main_bus_resp,
    output logic [sysbus_pkg::bus_tag_width-1:0]  main_bus_resptag
);
    import sysbus_pkg::*;

    logic [1:0] state;
    logic [$clog2(beats_per_line)-1:0] beat;
    logic [line_index_width-1:0] line_idx;
    bus_tag_u req_tag;
    bus_tag_u tag_q;
    logic addr_hit;
    logic last_beat;

    // One word per beat, addressed by line index and beat.
    logic [bus_data_width-1:0] mem [line_count*beats_per_line];

    assign req_tag   = main_bus_reqtag;
    assign addr_hit  = main_bus_reqcyc && (req_tag.f.device == sysbus_memory);
    assign last_beat = (beat == 3'(beats_per_line - 1));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= mem_idle;
            beat  <= '0;
        end
        else
        begin
            case (state)
                mem_idle:
                begin
                    beat <= '0;
                    if (addr_hit)
                        state <= (req_tag.f.dir == sysbus_write) ? mem_write : mem_read_wait;
                end
                mem_write:
                begin
                    if (main_bus_reqcyc)
                    begin
                        beat <= beat + 1'b1;
                        if (last_beat)
                            state <= mem_idle;
                    end
                end
                mem_read_wait:
                    state <= mem_read_stream;
                default:
                begin
                    beat <= beat + 1'b1;
                    if (last_beat)
                        state <= mem_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == mem_idle && addr_hit)
        begin
            line_idx <= main_bus_req[line_offset_width +: line_index_width];
            tag_q    <= req_tag;                                // Echoed on responses.
        end
        if (state == mem_write && main_bus_reqcyc)
            mem[{line_idx, beat}] <= main_bus_req;
    end

    // ============================================================
    // Response channel
    // ============================================================
    assign main_bus_reqack  = main_bus_reqcyc;
    assign main_bus_respcyc = (state == mem_read_stream);
    assign main_bus_resp    = main_bus_respcyc ? mem[{line_idx, beat}] : '0;
    assign main_bus_resptag = main_bus_respcyc ? tag_q.raw : '0;

    // The arbiter keeps the reader on the bus until its line is delivered.
    a_no_req_during_read: assert property (@(posedge clk) disable iff (reset)
        main_bus_reqcyc |-> (state == mem_idle || state == mem_write));

endmodule

`default_nettype wire

//--- source/mem_subsystem_top.sv
`default_nettype none

module mem_subsystem_top
(
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                wb_enable,
    input  logic [sysbus_pkg::bus_data_width-1:0] wb_addr,
    input  logic [sysbus_pkg::line_width-1:0]     wb_data,
    input  logic                                fill_enable,
    input  logic [sysbus_pkg::bus_data_width-1:0] fill_addr,
    output logic                                wb_ready,
    output logic                                fill_ready,
    output logic [sysbus_pkg::line_width-1:0]     fill_line
);
    import sysbus_pkg::*;

    // Master to arbiter.
    logic wb_abtr_reqcyc, wb_grant, wb_busy, wb_bus_reqcyc;
    logic fill_abtr_reqcyc, fill_grant, fill_busy, fill_bus_reqcyc;
    logic [bus_data_width-1:0] wb_bus_req, fill_bus_req;
    logic [bus_tag_width-1:0]  wb_bus_reqtag, fill_bus_reqtag;

    // Shared bus.
    logic main_bus_reqcyc, main_bus_reqack, main_bus_respcyc;
    logic [bus_data_width-1:0] main_bus_req, main_bus_resp;
    logic [bus_tag_width-1:0]  main_bus_reqtag, main_bus_resptag;

    bus_arbiter u_arbiter (
        .clk(clk), .reset(reset),
        .wb_reqcyc_arb(wb_abtr_reqcyc), .fill_reqcyc_arb(fill_abtr_reqcyc),
        .wb_busy(wb_busy), .fill_busy(fill_busy),
        .wb_bus_reqcyc(wb_bus_reqcyc), .wb_bus_req(wb_bus_req),
        .wb_bus_reqtag(wb_bus_reqtag),
        .fill_bus_reqcyc(fill_bus_reqcyc), .fill_bus_req(fill_bus_req),
        .fill_bus_reqtag(fill_bus_reqtag),
        .wb_grant(wb_grant), .fill_grant(fill_grant),
        .main_bus_reqcyc(main_bus_reqcyc), .main_bus_req(main_bus_req),
        .main_bus_reqtag(main_bus_reqtag)
    );

    line_writeback u_writeback (
        .clk(clk), .reset(reset), .enable(wb_enable),
        .addr(wb_addr), .data(wb_data),
        .abtr_grant(wb_grant), .main_bus_reqack(main_bus_reqack),
        .abtr_reqcyc(wb_abtr_reqcyc), .bus_busy(wb_busy),
        .main_bus_reqcyc(wb_bus_reqcyc), .main_bus_req(wb_bus_req),
        .main_bus_reqtag(wb_bus_reqtag), .ready(wb_ready)
    );

    line_fill u_fill (
        .clk(clk), .reset(reset), .enable(fill_enable), .addr(fill_addr),
        .abtr_grant(fill_grant),
        .main_bus_respcyc(main_bus_respcyc), .main_bus_resp(main_bus_resp),
        .main_bus_resptag(main_bus_resptag),
        .abtr_reqcyc(fill_abtr_reqcyc), .bus_busy(fill_busy),
        .main_bus_reqcyc(fill_bus_reqcyc), .main_bus_req(fill_bus_req),
        .main_bus_reqtag(fill_bus_reqtag),
        .main_bus_respack(),                                   // Memory never stalls.
        .line(fill_line), .ready(fill_ready)
    );

    line_memory u_memory (
        .clk(clk), .reset(reset),
        .main_bus_reqcyc(main_bus_reqcyc), .main_bus_req(main_bus_req),
        .main_bus_reqtag(main_bus_reqtag), .main_bus_reqack(main_bus_reqack),
        .main_bus_respcyc(main_bus_respcyc), .main_bus_resp(main_bus_resp),
        .main_bus_resptag(main_bus_resptag)
    );

endmodule

`default_nettype wire

//--- test/mem_subsystem_tb.sv
`default_nettype none

module mem_subsystem_tb;
    timeunit 1ns;
    timeprecision 1ns;
    import sysbus_pkg::*;

    localparam int test_count = 9;
    localparam int wait_limit = 60;
    localparam int data_count = 4;

    localparam logic [1:0] op_write = 2'd0;
    localparam logic [1:0] op_read  = 2'd1;
    localparam logic [1:0] op_both  = 2'd2;

    // ============================================================
    // Test table
    // ============================================================
    // Line index 5 lives at 0x140, line index 14 at 0x380.
    localparam logic [1:0] op_tab [test_count] = '{
        op_write, op_read, op_read, op_write, op_read,
        op_read, op_both, op_write, op_read
    };
    localparam logic [63:0] addr_tab [test_count] = '{
        64'h140, 64'h140, 64'h157, 64'h380, 64'h140,
        64'h39f, 64'h380, 64'h140, 64'h141
    };
    // Random line written, or expected back on a read.
    localparam logic [1:0] sel_tab [test_count] = '{
        2'd0, 2'd0, 2'd0, 2'd1, 2'd0,
        2'd1, 2'd2, 2'd3, 2'd3
    };

    logic clk = 1'b0;
    logic reset;
    logic wb_enable;
    logic [bus_data_width-1:0] wb_addr;
    logic [line_width-1:0] wb_data;
    logic fill_enable;
    logic [bus_data_width-1:0] fill_addr;
    logic wb_ready;
    logic fill_ready;
    logic [line_width-1:0] fill_line;

    logic [line_width-1:0] line_data [data_count];
    int passed;
    int failed;

    mem_subsystem_top dut_i (
        .clk(clk), .reset(reset),
        .wb_enable(wb_enable), .wb_addr(wb_addr), .wb_data(wb_data),
        .fill_enable(fill_enable), .fill_addr(fill_addr),
        .wb_ready(wb_ready), .fill_ready(fill_ready), .fill_line(fill_line)
    );

    always #50 clk = ~clk;

    function automatic string op_name(input logic [1:0] op);
        if (op == op_write)
            return "write";
        else if (op == op_read)
            return "read";
        return "write+read";
    endfunction

    // Called just after a falling edge. Enables are high for one cycle.
    task automatic pulse_enables(input logic do_wb, input logic do_fill,
                                 input logic [bus_data_width-1:0] addr,
                                 input logic [line_width-1:0] data);
        wb_addr     = addr;
        wb_data     = data;
        fill_addr   = addr;
        wb_enable   = do_wb;
        fill_enable = do_fill;
        @(negedge clk);
        wb_enable   = 1'b0;
        fill_enable = 1'b0;
    endtask

    task automatic wait_ready(input logic need_wb, input logic need_fill, output logic ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < wait_limit)
        begin
            @(negedge clk);
            ok = (!need_wb || wb_ready) && (!need_fill || fill_ready);
            cycles++;
        end
    endtask

    initial
    begin
        logic ok;
        logic test_ok;
        logic do_wb;
        logic do_fill;
        void'($urandom(93));
        reset       = 1'b1;
        wb_enable   = 1'b0;
        wb_addr     = '0;
        wb_data     = '0;
        fill_enable = 1'b0;
        fill_addr   = '0;
        passed      = 0;
        failed      = 0;
        for (int d = 0; d < data_count; d++)
            for (int w = 0; w < line_width / 32; w++)
                line_data[d][w*32 +: 32] = $urandom;

        repeat (3) @(negedge clk);
        reset = 1'b0;

        // Both masters idle out of reset.
        test_ok = 1'b1;
        if (wb_ready !== 1'b0)
        begin
            $display("ERROR wb_ready: expected 0, got %h", wb_ready);
            test_ok = 1'b0;
        end
        if (fill_ready !== 1'b0)
        begin
            $display("ERROR fill_ready: expected 0, got %h", fill_ready);
            test_ok = 1'b0;
        end
        if (test_ok) passed++;
        else failed++;
        $display("test 0 reset: %s", test_ok ? "pass" : "fail");

        // ============================================================
        // Table loop
        // ============================================================
        for (int t = 0; t < test_count; t++)
        begin
            test_ok = 1'b1;
            do_wb   = (op_tab[t] != op_read);
            do_fill = (op_tab[t] != op_write);
            pulse_enables(do_wb, do_fill, addr_tab[t], line_data[sel_tab[t]]);
            wait_ready(do_wb, do_fill, ok);
            if (!ok)
            begin
                $display("test %0d: ready did not rise within %0d cycles", t + 1, wait_limit);
                test_ok = 1'b0;
            end
            else if (do_fill && fill_line !== line_data[sel_tab[t]])
            begin
                $display("ERROR fill_line: expected %h, got %h",
                         line_data[sel_tab[t]], fill_line);
                test_ok = 1'b0;
            end
            if (test_ok) passed++;
            else failed++;
            $display("test %0d %s addr %h: %s", t + 1, op_name(op_tab[t]), addr_tab[t],
                     test_ok ? "pass" : "fail");
        end

        $display("tests %0d, passed %0d, failed %0d", passed + failed, passed, failed);
        if (failed == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
source/sysbus_pkg.sv
source/bus_arbiter.sv
source/line_writeback.sv
source/line_fill.sv
source/line_memory.sv
source/mem_subsystem_top.sv
test/mem_subsystem_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the simulation printed its pass line.
verilator --binary --timing --assert --top-module mem_subsystem_tb -f vlog.f \
    && ./obj_dir/Vmem_subsystem_tb | awk '{ print } /^No errors$/ { ok = 1 } END { exit !ok }' \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
